//--- Bender.yml
package:
  name: fft_twiddle_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/fft_pkg.sv
      - design/fft_sideband_delay.sv
      - design/fft_twiddle_ram.sv
      - design/fft_cmul_kar.sv
      - design/fft_twiddle_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/fft_twiddle_stage_tb.sv

//--- design/fft_cmul_kar.sv
`timescale 1ns/1ps
`include "fft_config.svh"

module fft_cmul_kar (
   input  logic              clk,
   input  logic              arst_n_i,
   input  fft_pkg::sample_t  a_re_i,
   input  fft_pkg::sample_t  a_im_i,
   input  fft_pkg::twiddle_t w_re_i,
   input  fft_pkg::twiddle_t w_im_i,
   output fft_pkg::sample_t  z_re_o,
   output fft_pkg::sample_t  z_im_o
);

   import fft_pkg::*;

   localparam int DW   = `FFT_DATA_W;
   localparam int TW   = `FFT_TW_W;
   localparam int PW   = DW + TW + 1;
   // fraction bits of the twiddle, the rounding point
   localparam int FRAC = TW - 1;

   // drop the msb, round half to even at FRAC, keep DW bits
   // the msb is only sign copy since |twiddle| <= 2**(TW-1)
   function automatic sample_t round_conv(input product_t p);
      logic [PW-2:0] trim;
      logic [PW-2:0] bias;
      logic [PW-2:0] sum;
      trim = p[PW-2:0];
      // half minus one lsb when the kept lsb is even, a full half when odd
      bias = {{(PW-1-FRAC){1'b0}}, trim[FRAC], {(FRAC-1){~trim[FRAC]}}};
      sum  = trim + bias;
      return sample_t'(sum[FRAC+DW-1:FRAC]);
   endfunction

   // stage 1
   sample_t                 a_re_q1;
   sample_t                 a_im_q1;
   twiddle_t                w_re_q1;
   twiddle_t                w_im_q1;

   // stage 2
   sample_t                 a_re_q2;
   sample_t                 a_im_q2;
   twiddle_t                w_re_q2;
   logic signed [DW:0]      e_q2;
   logic signed [TW:0]      ws_q2;
   logic signed [TW:0]      wd_q2;

   // stage 3
   product_t                f_q3;
   product_t                pr_q3;
   product_t                pi_q3;

   product_t                r_sum;
   product_t                i_sum;

   // (a + jb)(c + jd) with e = a - b and f = c*e
   // R = b(c - d) + f, I = a(c + d) - f
   assign r_sum = pr_q3 + f_q3;
   assign i_sum = pi_q3 - f_q3;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         a_re_q1 <= '0;
         a_im_q1 <= '0;
         w_re_q1 <= '0;
         w_im_q1 <= '0;
         a_re_q2 <= '0;
         a_im_q2 <= '0;
         w_re_q2 <= '0;
         e_q2    <= '0;
         ws_q2   <= '0;
         wd_q2   <= '0;
         f_q3    <= '0;
         pr_q3   <= '0;
         pi_q3   <= '0;
         z_re_o  <= '0;
         z_im_o  <= '0;
      end
      else
      begin
         a_re_q1 <= a_re_i;
         a_im_q1 <= a_im_i;
         w_re_q1 <= w_re_i;
         w_im_q1 <= w_im_i;

         // pre-adders, one bit wider than their inputs
         a_re_q2 <= a_re_q1;
         a_im_q2 <= a_im_q1;
         w_re_q2 <= w_re_q1;
         e_q2    <= a_re_q1 - a_im_q1;
         ws_q2   <= w_re_q1 + w_im_q1;
         wd_q2   <= w_re_q1 - w_im_q1;

         // the three multipliers
         f_q3    <= w_re_q2 * e_q2;
         pr_q3   <= a_im_q2 * wd_q2;
         pi_q3   <= a_re_q2 * ws_q2;

         z_re_o  <= round_conv(r_sum);
         z_im_o  <= round_conv(i_sum);
      end
   end

endmodule

//--- design/fft_pkg.sv
`include "fft_config.svh"

package fft_pkg;

   // index width follows the transform size
   localparam int IDX_W = $clog2(`FFT_N);

   // one component of a stream sample
   typedef logic signed [`FFT_DATA_W-1:0] sample_t;

   // one component of a twiddle factor
   typedef logic signed [`FFT_TW_W-1:0] twiddle_t;

   // position of a sample in the frame
   typedef logic [IDX_W-1:0] index_t;

   // full precision karatsuba term
   // sample plus widened twiddle, so no product can overflow
   typedef logic signed [`FFT_DATA_W+`FFT_TW_W:0] product_t;

endpackage

//--- design/fft_sideband_delay.sv
`timescale 1ns/1ps

module fft_sideband_delay #(
   parameter type T     = logic,
   parameter int  DEPTH = 1
) (
   input  logic clk,
   input  logic arst_n_i,
   input  T     d_i,
   output T     q_o
);

   // shift chain, entry 0 takes the input
   T stage_q [DEPTH];

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            stage_q[i] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= d_i;
         for (int i = 1; i < DEPTH; i++)
         begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign q_o = stage_q[DEPTH-1];

endmodule

//--- design/fft_twiddle_ram.sv
`timescale 1ns/1ps
`include "fft_config.svh"

module fft_twiddle_ram (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic [11:0]       paddr_i,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [31:0]       pwdata_i,
   output logic [31:0]       prdata_o,
   output logic              pready_o,
   output logic              pslverr_o,
   input  fft_pkg::index_t   rd_idx_i,
   output fft_pkg::twiddle_t w_re_o,
   output fft_pkg::twiddle_t w_im_o
);

   import fft_pkg::*;

   localparam int TW     = `FFT_TW_W;
   // imaginary part sits in the upper half word
   localparam int IM_LSB = 16;

   twiddle_t tab_re [`FFT_N];
   twiddle_t tab_im [`FFT_N];
   logic     access;
   logic     in_range;
   index_t   apb_idx;

   // access phase of an APB transfer
   assign access   = psel_i & penable_i;
   // one 32-bit word per index
   assign in_range = (paddr_i < 12'(4 * `FFT_N));
   assign apb_idx  = paddr_i[IDX_W+1:2];

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < `FFT_N; i++)
         begin
            tab_re[i] <= '0;
            tab_im[i] <= '0;
         end
      end
      else if (access && pwrite_i && in_range)
      begin
         tab_re[apb_idx] <= pwdata_i[TW-1:0];
         tab_im[apb_idx] <= pwdata_i[IM_LSB+TW-1:IM_LSB];
      end
   end

   // stream side lookup, one cycle behind the index
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         w_re_o <= '0;
         w_im_o <= '0;
      end
      else
      begin
         w_re_o <= tab_re[rd_idx_i];
         w_im_o <= tab_im[rd_idx_i];
      end
   end

   // out of range reads return zero, unused bits read as zero
   always_comb
   begin
      prdata_o = '0;
      if (access && !pwrite_i && in_range)
      begin
         prdata_o[TW-1:0]               = tab_re[apb_idx];
         prdata_o[IM_LSB+TW-1:IM_LSB]   = tab_im[apb_idx];
      end
   end

   assign pslverr_o = access & ~in_range;
   // no wait states
   assign pready_o  = 1'b1;

endmodule

//--- design/fft_twiddle_stage.sv
`timescale 1ns/1ps
`include "fft_config.svh"

module fft_twiddle_stage (
   input  logic              clk,
   input  logic              arst_n_i,
   input  fft_pkg::sample_t  x_re_i,
   input  fft_pkg::sample_t  x_im_i,
   input  fft_pkg::index_t   ctr_i,
   input  logic              carry_i,
   output fft_pkg::sample_t  z_re_o,
   output fft_pkg::sample_t  z_im_o,
   output fft_pkg::index_t   ctr_o,
   output logic              carry_o,
   input  logic [11:0]       paddr_i,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [31:0]       pwdata_i,
   output logic [31:0]       prdata_o,
   output logic              pready_o,
   output logic              pslverr_o
);

   import fft_pkg::*;

   // table lookup plus multiplier
   localparam int SIDE_DEPTH = `FFT_MUL_LAT + 1;

   sample_t  x_re_d;
   sample_t  x_im_d;
   twiddle_t w_re;
   twiddle_t w_im;

   // the sample index addresses the table directly
   fft_twiddle_ram u_twiddle_ram (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .rd_idx_i  (ctr_i),
      .w_re_o    (w_re),
      .w_im_o    (w_im)
   );

   // sample waits one cycle for its twiddle
   fft_sideband_delay #(.T(sample_t), .DEPTH(1)) u_dly_re (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .d_i      (x_re_i),
      .q_o      (x_re_d)
   );

   fft_sideband_delay #(.T(sample_t), .DEPTH(1)) u_dly_im (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .d_i      (x_im_i),
      .q_o      (x_im_d)
   );

   fft_cmul_kar u_cmul (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .a_re_i   (x_re_d),
      .a_im_i   (x_im_d),
      .w_re_i   (w_re),
      .w_im_i   (w_im),
      .z_re_o   (z_re_o),
      .z_im_o   (z_im_o)
   );

   // index and carry ride alongside the product
   fft_sideband_delay #(.T(index_t), .DEPTH(SIDE_DEPTH)) u_dly_ctr (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .d_i      (ctr_i),
      .q_o      (ctr_o)
   );

   fft_sideband_delay #(.T(logic), .DEPTH(SIDE_DEPTH)) u_dly_carry (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .d_i      (carry_i),
      .q_o      (carry_o)
   );

endmodule

//--- include/fft_config.svh
`ifndef FFT_CONFIG_SVH
`define FFT_CONFIG_SVH

// bits per sample component, real and imaginary alike
`define FFT_DATA_W 16

// bits per twiddle component
// a twiddle integer k stands for k / 2**(FFT_TW_W-1)
`define FFT_TW_W 10

// transform size, sets the twiddle table depth and the index width
`define FFT_N 64

// register stages through the complex multiplier
`define FFT_MUL_LAT 4

`endif

//--- sim.f
+incdir+include
design/fft_pkg.sv
design/fft_sideband_delay.sv
design/fft_twiddle_ram.sv
design/fft_cmul_kar.sv
design/fft_twiddle_stage.sv
verif/fft_twiddle_stage_tb.sv

//--- verif/fft_twiddle_stage_tb.sv
`timescale 1ns/1ps
`include "fft_config.svh"

module fft_twiddle_stage_tb;

   import fft_pkg::*;

   localparam int CLK_PERIOD  = 20;
   localparam int RST_CYCLES  = 16;
   localparam int PIPE_DEPTH  = `FFT_MUL_LAT + 1;
   // reset, table fill and readback, three streams, tie table refill, flush
   localparam int TEST_CYCLES = 720;
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
   localparam int FRAC        = `FFT_TW_W - 1;
   localparam int KEEP_SHIFT  = 64 - (`FFT_DATA_W + `FFT_TW_W);

   logic        clk;
   logic        arst_n_i;
   sample_t     x_re_i;
   sample_t     x_im_i;
   index_t      ctr_i;
   logic        carry_i;
   sample_t     z_re_o;
   sample_t     z_im_o;
   index_t      ctr_o;
   logic        carry_o;
   logic [11:0] paddr_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;

   // next stream sample that is held while an apb transfer runs
   sample_t     nxt_re;
   sample_t     nxt_im;
   index_t      nxt_ctr;
   logic        nxt_carry;

   // mirror of the twiddle table as the stream port sees it
   twiddle_t    tab_re_m [`FFT_N];
   twiddle_t    tab_im_m [`FFT_N];

   sample_t     exp_re_q [$];
   sample_t     exp_im_q [$];
   index_t      exp_ctr_q [$];
   logic        exp_carry_q [$];

   logic [31:0] lcg_state = 32'h3115;
   int          cycle_cnt = 0;

   fft_twiddle_stage dut (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .x_re_i    (x_re_i),
      .x_im_i    (x_im_i),
      .ctr_i     (ctr_i),
      .carry_i   (carry_i),
      .z_re_o    (z_re_o),
      .z_im_o    (z_im_o),
      .ctr_o     (ctr_o),
      .carry_o   (carry_o),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #(CLK_PERIOD/2) clk = ~clk;

   task automatic fail_stop(input string line);
      $display("%s", line);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         fail_stop("timeout: the tests did not finish within the cycle limit");
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic sample_t rand_sample();
      return sample_t'(lcg_next() >> 16);
   endfunction

   function automatic twiddle_t rand_twiddle();
      twiddle_t t;
      t = twiddle_t'(lcg_next() >> 12);
      // -512 is the one code above the allowed magnitude
      if (t == -512)
      begin
         t = -511;
      end
      return t;
   endfunction

   function automatic logic [31:0] pack_tw(input twiddle_t re, input twiddle_t im);
      logic [31:0] word;
      word = '0;
      word[FRAC:0] = re;
      word[16+FRAC:16] = im;
      return word;
   endfunction

   // keep 26 bits, then round half to even at bit 9 and keep 16 bits
   function automatic sample_t round_model(input longint v);
      longint t;
      longint q;
      longint rem;
      t   = (v <<< KEEP_SHIFT) >>> KEEP_SHIFT;
      q   = t >>> FRAC;
      rem = t - (q <<< FRAC);
      if ((rem > (1 <<< (FRAC-1))) || ((rem == (1 <<< (FRAC-1))) && q[0]))
      begin
         q = q + 1;
      end
      return sample_t'(q[`FFT_DATA_W-1:0]);
   endfunction

   task automatic model_mul(input sample_t xr, input sample_t xi, input twiddle_t wr,
                            input twiddle_t wi, output sample_t zr, output sample_t zi);
      zr = round_model(longint'(xr) * longint'(wr) - longint'(xi) * longint'(wi));
      zi = round_model(longint'(xr) * longint'(wi) + longint'(xi) * longint'(wr));
   endtask

   task automatic cmp_sample(input string what, input sample_t got, input sample_t exp);
      if (got !== exp)
      begin
         fail_stop($sformatf("ERR %0t %s got %0d expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic cmp_index(input string what, input index_t got, input index_t exp);
      if (got !== exp)
      begin
         fail_stop($sformatf("ERR %0t %s got %0d expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic cmp_bit(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         fail_stop($sformatf("ERR %0t %s got %b expected %b", $time, what, got, exp));
      end
   endtask

   task automatic cmp_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         fail_stop($sformatf("ERR %0t %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   // check the result of five cycles ago and drive the next sample on each clock
   task automatic cycle();
      sample_t er;
      sample_t ei;
      @(negedge clk);
      if (exp_re_q.size() == PIPE_DEPTH)
      begin
         cmp_sample("z_re_o", z_re_o, exp_re_q.pop_front());
         cmp_sample("z_im_o", z_im_o, exp_im_q.pop_front());
         cmp_index("ctr_o", ctr_o, exp_ctr_q.pop_front());
         cmp_bit("carry_o", carry_o, exp_carry_q.pop_front());
      end
      psel_i    = 1'b0;
      penable_i = 1'b0;
      x_re_i    = nxt_re;
      x_im_i    = nxt_im;
      ctr_i     = nxt_ctr;
      carry_i   = nxt_carry;
      model_mul(nxt_re, nxt_im, tab_re_m[nxt_ctr], tab_im_m[nxt_ctr], er, ei);
      exp_re_q.push_back(er);
      exp_im_q.push_back(ei);
      exp_ctr_q.push_back(nxt_ctr);
      exp_carry_q.push_back(nxt_carry);
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic exp_err);
      cycle();
      paddr_i  = addr;
      pwdata_i = data;
      pwrite_i = 1'b1;
      psel_i   = 1'b1;
      cycle();
      psel_i    = 1'b1;
      penable_i = 1'b1;
      // the table changes at the edge closing the access phase
      if (addr < 12'(4 * `FFT_N))
      begin
         tab_re_m[addr[IDX_W+1:2]] = data[FRAC:0];
         tab_im_m[addr[IDX_W+1:2]] = data[16+FRAC:16];
      end
      #(CLK_PERIOD/4);
      cmp_bit("pready_o on write", pready_o, 1'b1);
      cmp_bit("pslverr_o on write", pslverr_o, exp_err);
   endtask

   task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp_data,
                           input logic exp_err);
      cycle();
      paddr_i  = addr;
      pwrite_i = 1'b0;
      psel_i   = 1'b1;
      cycle();
      psel_i    = 1'b1;
      penable_i = 1'b1;
      #(CLK_PERIOD/4);
      cmp_bit("pready_o on read", pready_o, 1'b1);
      cmp_bit("pslverr_o on read", pslverr_o, exp_err);
      cmp_word("prdata_o", prdata_o, exp_data);
   endtask

   task automatic test_reset();
      cmp_sample("z_re_o after reset", z_re_o, '0);
      cmp_sample("z_im_o after reset", z_im_o, '0);
      cmp_index("ctr_o after reset", ctr_o, '0);
      cmp_bit("carry_o after reset", carry_o, 1'b0);
      cmp_bit("pslverr_o after reset", pslverr_o, 1'b0);
      cmp_word("prdata_o after reset", prdata_o, '0);
      apb_read(12'(4 * 5), 32'h0, 1'b0);
   endtask

   task automatic test_table_rw();
      logic [31:0] saved;
      for (int i = 0; i < `FFT_N; i++)
      begin
         apb_write(12'(4 * i), pack_tw(rand_twiddle(), rand_twiddle()), 1'b0);
      end
      for (int i = 0; i < `FFT_N; i++)
      begin
         apb_read(12'(4 * i), pack_tw(tab_re_m[i], tab_im_m[i]), 1'b0);
      end
      // first address past the table aliases index 0 in its low bits
      saved = pack_tw(tab_re_m[0], tab_im_m[0]);
      apb_write(12'(4 * `FFT_N), saved ^ 32'h03FF_03FF, 1'b1);
      apb_read(12'(4 * `FFT_N), 32'h0, 1'b1);
      apb_read(12'h0, saved, 1'b0);
   endtask

   task automatic test_random_stream();
      for (int i = 0; i < 200; i++)
      begin
         nxt_re    = rand_sample();
         nxt_im    = rand_sample();
         nxt_ctr   = index_t'(lcg_next() >> 20);
         nxt_carry = 1'(lcg_next() >> 31);
         cycle();
      end
   endtask

   task automatic test_sideband();
      for (int i = 0; i < 48; i++)
      begin
         // four used slots then two empty ones
         nxt_carry = ((i % 6) < 4);
         nxt_ctr   = index_t'(i);
         nxt_re    = nxt_carry ? rand_sample() : sample_t'(0);
         nxt_im    = nxt_carry ? rand_sample() : sample_t'(0);
         cycle();
      end
   endtask

   task automatic test_write_during_stream();
      twiddle_t new_re;
      twiddle_t new_im;
      nxt_ctr   = index_t'(7);
      nxt_carry = 1'b1;
      for (int i = 0; i < 6; i++)
      begin
         nxt_re = rand_sample();
         nxt_im = rand_sample();
         cycle();
      end
      // a value that always differs from the old entry
      new_re = (tab_re_m[7] > 0) ? twiddle_t'(tab_re_m[7] - 300) : twiddle_t'(tab_re_m[7] + 300);
      new_im = (tab_im_m[7] > 0) ? twiddle_t'(tab_im_m[7] - 300) : twiddle_t'(tab_im_m[7] + 300);
      apb_write(12'(4 * 7), pack_tw(new_re, new_im), 1'b0);
      for (int i = 0; i < 6; i++)
      begin
         nxt_re = rand_sample();
         nxt_im = rand_sample();
         cycle();
      end
   endtask

   task automatic test_rounding();
      // x * 511 lands exactly halfway when x is 256 mod 512
      sample_t ties [8] = '{256, 768, -256, -768, 1280, -1280, 32000, -32000};
      nxt_re    = '0;
      nxt_im    = '0;
      nxt_carry = 1'b0;
      for (int i = 0; i < `FFT_N; i++)
      begin
         apb_write(12'(4 * i), pack_tw(twiddle_t'(511), twiddle_t'(0)), 1'b0);
      end
      nxt_carry = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         nxt_re  = ties[i];
         nxt_im  = ties[7-i];
         nxt_ctr = index_t'(i * 9);
         cycle();
      end
      for (int i = 0; i < 16; i++)
      begin
         nxt_re  = rand_sample();
         nxt_im  = rand_sample();
         nxt_ctr = index_t'(lcg_next() >> 20);
         cycle();
      end
   endtask

   initial
   begin
      arst_n_i  = 1'b0;
      x_re_i    = '0;
      x_im_i    = '0;
      ctr_i     = '0;
      carry_i   = 1'b0;
      paddr_i   = '0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      pwdata_i  = '0;
      nxt_re    = '0;
      nxt_im    = '0;
      nxt_ctr   = '0;
      nxt_carry = 1'b0;
      for (int i = 0; i < `FFT_N; i++)
      begin
         tab_re_m[i] = '0;
         tab_im_m[i] = '0;
      end
      repeat (RST_CYCLES) @(negedge clk);
      arst_n_i = 1'b1;

      test_reset();
      test_table_rw();
      test_random_stream();
      test_sideband();
      test_write_during_stream();
      test_rounding();

      // drain the pipeline with idle slots
      nxt_re    = '0;
      nxt_im    = '0;
      nxt_ctr   = '0;
      nxt_carry = 1'b0;
      repeat (PIPE_DEPTH) cycle();

      $display("Result: PASSED");
      $finish;
   end

endmodule
